//--- src/board_bus_pkg.sv
`default_nettype none

package board_bus_pkg;

    // bus widths
    typedef logic [63:0] addr_t;
    typedef logic [63:0] dword_t;
    // one ram word or one plic register
    typedef logic [31:0] word_t;
    // plic priority and threshold
    typedef logic [2:0]  prio_t;

    // load/store type as the core encodes it
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_t;

    // decoded target of one bus access
    typedef enum logic [3:0] {
        REG_NONE,
        REG_RAM,
        REG_PLIC_PRIORITY,
        REG_PLIC_PENDING,
        REG_PLIC_ENABLE,
        REG_PLIC_THRESHOLD,
        REG_PLIC_CLAIM,
        REG_MTIME,
        REG_MTIMECMP
    } region_t;

    // request held by the core until done rises
    typedef struct packed {
        addr_t    addr;
        dword_t   wdata;
        ls_type_t ls_type;
    } bus_req_t;

    // address map
    parameter word_t RAM_BASE      = 32'h0000_1000;
    parameter word_t PLIC_BASE     = 32'h0C00_0000;
    parameter word_t MTIME_ADDR    = 32'h0200_BFF8;
    parameter word_t MTIMECMP_ADDR = 32'h0200_4000;

    parameter int DEFAULT_RAM_WORDS   = 1024;
    parameter int DEFAULT_NUM_SOURCES = 5;

endpackage

`default_nettype wire

//--- src/addr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module addr_decoder import board_bus_pkg::*; #(
    parameter int RAM_WORDS   = DEFAULT_RAM_WORDS,
    parameter int NUM_SOURCES = DEFAULT_NUM_SOURCES
) (
    input  addr_t   addr,
    output region_t region,
    output addr_t   offset
);
    // ram window in bytes
    localparam addr_t RAM_LO  = addr_t'(RAM_BASE);
    localparam addr_t RAM_HI  = RAM_LO + addr_t'(RAM_WORDS) * 4;
    // plic register bases
    localparam addr_t PLIC_LO = addr_t'(PLIC_BASE);
    localparam addr_t PRIO_HI = PLIC_LO + addr_t'(NUM_SOURCES + 1) * 4;
    localparam addr_t PEND    = PLIC_LO + 64'h1000;
    localparam addr_t ENA     = PLIC_LO + 64'h2000;
    localparam addr_t THR     = PLIC_LO + 64'h20_0000;
    localparam addr_t CLM     = THR + 64'h4;

    always_comb begin
        region = REG_NONE;
        offset = '0;
        if (addr >= RAM_LO && addr < RAM_HI) begin
            region = REG_RAM;
            offset = addr - RAM_LO;
        end else if (addr >= PLIC_LO && addr < PRIO_HI) begin
            // ids past NUM_SOURCES fall out of range
            region = REG_PLIC_PRIORITY;
            offset = addr - PLIC_LO;
        end else if (addr == PEND) begin
            region = REG_PLIC_PENDING;
        end else if (addr == ENA || addr == ENA + 64'h80) begin
            // bit 0 carries the context
            region    = REG_PLIC_ENABLE;
            offset[0] = addr != ENA;
        end else if (addr == THR || addr == THR + 64'h1000) begin
            region    = REG_PLIC_THRESHOLD;
            offset[0] = addr != THR;
        end else if (addr == CLM || addr == CLM + 64'h1000) begin
            region    = REG_PLIC_CLAIM;
            offset[0] = addr != CLM;
        end else if (addr == addr_t'(MTIME_ADDR)) begin
            region = REG_MTIME;
        end else if (addr == addr_t'(MTIMECMP_ADDR)) begin
            region = REG_MTIMECMP;
        end
    end

endmodule

`default_nettype wire

//--- src/bus_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module bus_fsm import board_bus_pkg::*; (
    input  logic     CLOCK_50,
    input  logic     KEY0,
    input  logic     read_enable,
    input  logic     write_enable,
    input  bus_req_t req,
    input  region_t  region,
    input  dword_t   ram_data,
    input  word_t    plic_data,
    input  dword_t   mtime,
    input  dword_t   mtimecmp,
    output logic     read_done,
    output logic     write_done,
    output dword_t   read_data,
    output logic     ram_rd_beat,
    output logic     ram_wr_beat,
    output logic     beat,
    output logic     plic_wr,
    output logic     plic_claim,
    output logic     cmp_wr
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_SECOND
    } state_t;

    state_t  state;
    // region, direction and size latched at the enable edge
    region_t region_q;
    logic    is_read;
    logic    is_dword;
    logic    busy;
    dword_t  sel_data;

    assign busy = state != ST_IDLE;
    // second beat moves the ram index one word up
    assign beat = state == ST_SECOND;

    // strobes only while a beat is live
    assign ram_rd_beat = busy && is_read && region_q == REG_RAM;
    assign ram_wr_beat = busy && !is_read && region_q == REG_RAM;
    assign plic_wr     = state == ST_ACCESS && !is_read
                         && (region_q == REG_PLIC_PRIORITY
                             || region_q == REG_PLIC_ENABLE
                             || region_q == REG_PLIC_THRESHOLD);
    // a claim read pops the pending bit
    assign plic_claim  = state == ST_ACCESS && is_read && region_q == REG_PLIC_CLAIM;
    assign cmp_wr      = state == ST_ACCESS && !is_read && region_q == REG_MTIMECMP;

    // single beat read value, zero extended
    always_comb begin
        case (region_q)
            REG_RAM:            sel_data = ram_data;
            REG_PLIC_PRIORITY,
            REG_PLIC_PENDING,
            REG_PLIC_ENABLE,
            REG_PLIC_THRESHOLD,
            REG_PLIC_CLAIM:     sel_data = {32'd0, plic_data};
            REG_MTIME:          sel_data = mtime;
            REG_MTIMECMP:       sel_data = mtimecmp;
            default:            sel_data = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= ST_IDLE;
            region_q   <= REG_NONE;
            is_read    <= 1'b0;
            is_dword   <= 1'b0;
            read_done  <= 1'b1;
            write_done <= 1'b1;
            read_data  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // pulses while busy never reach here
                    if (read_enable || write_enable) begin
                        state      <= ST_ACCESS;
                        region_q   <= region;
                        is_read    <= read_enable;
                        is_dword   <= req.ls_type == LS_D && region == REG_RAM;
                        read_done  <= !read_enable;
                        write_done <= !write_enable;
                    end
                end
                ST_ACCESS: begin
                    if (is_dword) begin
                        // low word first
                        state <= ST_SECOND;
                        if (is_read) begin
                            read_data[31:0] <= ram_data[31:0];
                        end
                    end else begin
                        state      <= ST_IDLE;
                        read_done  <= 1'b1;
                        write_done <= 1'b1;
                        if (is_read) begin
                            read_data <= sel_data;
                        end
                    end
                end
                ST_SECOND: begin
                    state      <= ST_IDLE;
                    read_done  <= 1'b1;
                    write_done <= 1'b1;
                    if (is_read) begin
                        read_data[63:32] <= ram_data[31:0];
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/word_ram.sv
`timescale 1ns/1ns
`default_nettype none

module word_ram import board_bus_pkg::*; #(
    parameter int RAM_WORDS = DEFAULT_RAM_WORDS
) (
    input  logic     CLOCK_50,
    input  bus_req_t req,
    input  logic     ram_wr_beat,
    input  logic     ram_rd_beat,
    input  logic     beat,
    output dword_t   ram_data
);
    localparam int AW = $clog2(RAM_WORDS);

    word_t         mem [RAM_WORDS];
    addr_t         ofs;
    logic [AW-1:0] idx;
    logic [1:0]    lane;
    logic [3:0]    be;
    word_t         wr_word;
    word_t         rd_word;
    word_t         shifted;
    dword_t        load;

    // byte offset into the ram window
    assign ofs  = req.addr - addr_t'(RAM_BASE);
    assign lane = ofs[1:0];
    // second beat takes the next word
    assign idx  = ofs[AW+1:2] + AW'(beat);

    // byte enables and lane-replicated store data
    always_comb begin
        case (req.ls_type)
            LS_B: begin
                be      = 4'b0001 << lane;
                wr_word = {4{req.wdata[7:0]}};
            end
            LS_H: begin
                be      = 4'b0011 << lane;
                wr_word = {2{req.wdata[15:0]}};
            end
            LS_D: begin
                be      = 4'b1111;
                wr_word = beat ? req.wdata[63:32] : req.wdata[31:0];
            end
            default: begin
                be      = 4'b1111;
                wr_word = req.wdata[31:0];
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_wr_beat) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[idx][8*i +: 8] <= wr_word[8*i +: 8];
                end
            end
        end
    end

    // loads shift the addressed byte down to bit 0
    assign rd_word = mem[idx];
    assign shifted = rd_word >> (8 * lane);

    always_comb begin
        case (req.ls_type)
            LS_B:    load = {{56{shifted[7]}}, shifted[7:0]};
            LS_H:    load = {{48{shifted[15]}}, shifted[15:0]};
            LS_W:    load = {{32{shifted[31]}}, shifted};
            // each dword beat returns its raw word
            LS_D:    load = {32'd0, rd_word};
            LS_BU:   load = {56'd0, shifted[7:0]};
            LS_HU:   load = {48'd0, shifted[15:0]};
            LS_WU:   load = {32'd0, shifted};
            default: load = '0;
        endcase
    end

    // nothing on the data lines outside a read beat
    assign ram_data = ram_rd_beat ? load : '0;

endmodule

`default_nettype wire

//--- src/plic.sv
`timescale 1ns/1ns
`default_nettype none

module plic import board_bus_pkg::*; #(
    parameter int NUM_SOURCES = DEFAULT_NUM_SOURCES
) (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic [NUM_SOURCES-1:0] irq_sources,
    input  addr_t                  offset,
    input  dword_t                 wdata,
    input  logic                   plic_wr,
    input  logic                   plic_claim,
    input  region_t                region,
    output word_t                  plic_data,
    output logic                   ext_irq_m,
    output logic                   ext_irq_s
);
    localparam int IW = $clog2(NUM_SOURCES + 1);

    // id 0 means no interrupt, its slot stays zero
    prio_t                prio [NUM_SOURCES+1];
    logic [NUM_SOURCES:0] pending;
    logic [NUM_SOURCES:0] enable [2];
    prio_t                thresh [2];
    logic [IW-1:0]        claim_id [2];
    logic [IW-1:0]        id;
    logic                 ctx;

    // priority word index, or context for per-context regs
    assign id  = offset[IW+1:2];
    assign ctx = offset[0];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i <= NUM_SOURCES; i++) begin
                prio[i] <= '0;
            end
            enable[0] <= '0;
            enable[1] <= '0;
            thresh[0] <= '0;
            thresh[1] <= '0;
        end else if (plic_wr) begin
            case (region)
                REG_PLIC_PRIORITY: begin
                    if (id != 0) begin
                        prio[id] <= wdata[2:0];
                    end
                end
                // bit 0 has no source behind it
                REG_PLIC_ENABLE:    enable[ctx] <= {wdata[NUM_SOURCES:1], 1'b0};
                REG_PLIC_THRESHOLD: thresh[ctx] <= wdata[2:0];
                default: ;
            endcase
        end
    end

    // level sources latch pending, claim clears and wins
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending <= '0;
        end else begin
            for (int i = 1; i <= NUM_SOURCES; i++) begin
                if (plic_claim && claim_id[ctx] == IW'(i)) begin
                    pending[i] <= 1'b0;
                end else if (irq_sources[i-1]) begin
                    pending[i] <= 1'b1;
                end
            end
        end
    end

    // strictly highest priority above threshold, low id on a tie
    always_comb begin
        prio_t best;
        for (int c = 0; c < 2; c++) begin
            best        = thresh[c];
            claim_id[c] = '0;
            for (int i = 1; i <= NUM_SOURCES; i++) begin
                if (pending[i] && enable[c][i] && prio[i] > best) begin
                    best        = prio[i];
                    claim_id[c] = IW'(i);
                end
            end
        end
    end

    // register read back
    always_comb begin
        case (region)
            REG_PLIC_PRIORITY:  plic_data = word_t'(prio[id]);
            REG_PLIC_PENDING:   plic_data = word_t'(pending);
            REG_PLIC_ENABLE:    plic_data = word_t'(enable[ctx]);
            REG_PLIC_THRESHOLD: plic_data = word_t'(thresh[ctx]);
            REG_PLIC_CLAIM:     plic_data = word_t'(claim_id[ctx]);
            default:            plic_data = '0;
        endcase
    end

    // context 0 machine, context 1 supervisor
    assign ext_irq_m = claim_id[0] != 0;
    assign ext_irq_s = claim_id[1] != 0;

endmodule

`default_nettype wire

//--- src/machine_timer.sv
`timescale 1ns/1ns
`default_nettype none

module machine_timer import board_bus_pkg::*; (
    input  logic   CLOCK_50,
    input  logic   KEY0,
    input  logic   cmp_wr,
    input  dword_t wdata,
    output dword_t mtime,
    output dword_t mtimecmp,
    output logic   timer_irq
);

    // free running, one tick per clock
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    // all ones keeps the irq quiet after reset
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtimecmp <= '1;
        end else if (cmp_wr) begin
            mtimecmp <= wdata;
        end
    end

    // level, holds until mtimecmp moves up
    assign timer_irq = mtime >= mtimecmp;

endmodule

`default_nettype wire

//--- src/board_bus.sv
`timescale 1ns/1ns
`default_nettype none

module board_bus import board_bus_pkg::*; #(
    parameter int RAM_WORDS   = DEFAULT_RAM_WORDS,
    parameter int NUM_SOURCES = DEFAULT_NUM_SOURCES
) (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  bus_req_t               req,
    input  logic                   read_enable,
    input  logic                   write_enable,
    input  logic [NUM_SOURCES-1:0] irq_sources,
    output logic                   read_done,
    output logic                   write_done,
    output dword_t                 read_data,
    output logic                   ext_irq_m,
    output logic                   ext_irq_s,
    output logic                   timer_irq
);
    region_t region;
    addr_t   offset;
    dword_t  ram_data;
    word_t   plic_data;
    dword_t  mtime;
    dword_t  mtimecmp;
    logic    ram_rd_beat;
    logic    ram_wr_beat;
    logic    beat;
    logic    plic_wr;
    logic    plic_claim;
    logic    cmp_wr;

    addr_decoder #(
        .RAM_WORDS   (RAM_WORDS),
        .NUM_SOURCES (NUM_SOURCES)
    ) i_addr_decoder (
        .addr   (req.addr),
        .region (region),
        .offset (offset)
    );

    // transaction control, steers every target
    bus_fsm i_bus_fsm (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .req          (req),
        .region       (region),
        .ram_data     (ram_data),
        .plic_data    (plic_data),
        .mtime        (mtime),
        .mtimecmp     (mtimecmp),
        .read_done    (read_done),
        .write_done   (write_done),
        .read_data    (read_data),
        .ram_rd_beat  (ram_rd_beat),
        .ram_wr_beat  (ram_wr_beat),
        .beat         (beat),
        .plic_wr      (plic_wr),
        .plic_claim   (plic_claim),
        .cmp_wr       (cmp_wr)
    );

    word_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_word_ram (
        .CLOCK_50    (CLOCK_50),
        .req         (req),
        .ram_wr_beat (ram_wr_beat),
        .ram_rd_beat (ram_rd_beat),
        .beat        (beat),
        .ram_data    (ram_data)
    );

    plic #(
        .NUM_SOURCES (NUM_SOURCES)
    ) i_plic (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .irq_sources (irq_sources),
        .offset      (offset),
        .wdata       (req.wdata),
        .plic_wr     (plic_wr),
        .plic_claim  (plic_claim),
        .region      (region),
        .plic_data   (plic_data),
        .ext_irq_m   (ext_irq_m),
        .ext_irq_s   (ext_irq_s)
    );

    machine_timer i_machine_timer (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .cmp_wr    (cmp_wr),
        .wdata     (req.wdata),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

//--- testbench/board_bus_tb.sv
`timescale 1ns/1ns
`default_nettype none

module board_bus_tb import board_bus_pkg::*;;

    // kinds of table entries
    typedef enum logic [2:0] {
        OP_READ,
        OP_WRITE,
        OP_SOURCES,
        OP_LEVEL,
        OP_WAIT,
        OP_TIME,
        OP_CMP
    } op_t;

    // which interrupt output an entry looks at
    typedef enum logic [1:0] {
        SEL_M,
        SEL_S,
        SEL_T
    } irq_sel_t;

    typedef struct packed {
        op_t        op;
        addr_t      addr;
        ls_type_t   ls;
        dword_t     wdata;
        dword_t     exp_val;
        irq_sel_t   sel;
        logic [1:0] beats;
    } entry_t;

    // plic register addresses, context 1 above context 0
    localparam addr_t PRIO = addr_t'(PLIC_BASE);
    localparam addr_t PEND = PRIO + 64'h1000;
    localparam addr_t ENA0 = PRIO + 64'h2000;
    localparam addr_t ENA1 = ENA0 + 64'h80;
    localparam addr_t THR0 = PRIO + 64'h20_0000;
    localparam addr_t THR1 = THR0 + 64'h1000;
    localparam addr_t CLM0 = THR0 + 64'h4;
    localparam addr_t CLM1 = THR1 + 64'h4;

    logic                           CLOCK_50 = 1'b0;
    logic                           KEY0 = 1'b0;
    bus_req_t                       req = '0;
    logic                           read_enable = 1'b0;
    logic                           write_enable = 1'b0;
    logic [DEFAULT_NUM_SOURCES-1:0] irq_sources = '0;
    logic                           read_done;
    logic                           write_done;
    dword_t                         read_data;
    logic                           ext_irq_m;
    logic                           ext_irq_s;
    logic                           timer_irq;

    entry_t steps [$];
    // expected ram contents, one entry per word
    word_t  ram_model [DEFAULT_RAM_WORDS];
    int     seed = 32'h3f49_cb65;
    dword_t last_mtime = '0;

    board_bus #(
        .RAM_WORDS   (DEFAULT_RAM_WORDS),
        .NUM_SOURCES (DEFAULT_NUM_SOURCES)
    ) i_board_bus (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .req          (req),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .irq_sources  (irq_sources),
        .read_done    (read_done),
        .write_done   (write_done),
        .read_data    (read_data),
        .ext_irq_m    (ext_irq_m),
        .ext_irq_s    (ext_irq_s),
        .timer_irq    (timer_irq)
    );

    // 40 ns period
    always #20 CLOCK_50 = ~CLOCK_50;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_dword(input string name, input dword_t got, input dword_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH time=%0t ns signal=%s got=%h expected=%h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH time=%0t ns signal=%s got=%b expected=%b",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("MISMATCH time=%0t ns signal=%s got=%0d expected=%0d",
                               $time, name, got, exp));
        end
    endtask

    // mtime must move strictly up between reads
    task automatic check_rising(input dword_t got, input dword_t prev);
        if (got <= prev) begin
            fail_run($sformatf("MISMATCH time=%0t ns signal=mtime got=%h expected above %h",
                               $time, got, prev));
        end
    endtask

    function automatic word_t rnd();
        return word_t'($random(seed));
    endfunction

    // byte-addressed store into the model
    function automatic void model_store(addr_t a, ls_type_t ls, dword_t d);
        int    idx;
        int    lane;
        word_t w;
        idx  = int'((a - addr_t'(RAM_BASE)) >> 2);
        lane = int'(a[1:0]);
        w    = ram_model[idx];
        case (ls)
            LS_B: w[8*lane +: 8] = d[7:0];
            LS_H: w[8*lane +: 16] = d[15:0];
            LS_D: begin
                // high word lands one address up
                ram_model[idx+1] = d[63:32];
                w = d[31:0];
            end
            default: w = d[31:0];
        endcase
        ram_model[idx] = w;
    endfunction

    // expected load value with sign or zero extension
    function automatic dword_t model_load(addr_t a, ls_type_t ls);
        int         idx;
        int         lane;
        word_t      w;
        logic [7:0] b;
        logic [15:0] h;
        idx  = int'((a - addr_t'(RAM_BASE)) >> 2);
        lane = int'(a[1:0]);
        w    = ram_model[idx];
        b    = 8'(w >> (8 * lane));
        h    = 16'(w >> (8 * lane));
        case (ls)
            LS_B:    return {{56{b[7]}}, b};
            LS_BU:   return {56'd0, b};
            LS_H:    return {{48{h[15]}}, h};
            LS_HU:   return {48'd0, h};
            LS_W:    return {{32{w[31]}}, w};
            LS_WU:   return {32'd0, w};
            LS_D:    return {ram_model[idx+1], w};
            default: return '0;
        endcase
    endfunction

    function automatic void push_entry(op_t op, addr_t a, ls_type_t ls, dword_t wd,
                                       dword_t ev, irq_sel_t s);
        entry_t e;
        logic   in_ram;
        in_ram    = a >= addr_t'(RAM_BASE)
                    && a < addr_t'(RAM_BASE) + addr_t'(DEFAULT_RAM_WORDS) * 4;
        e.op      = op;
        e.addr    = a;
        e.ls      = ls;
        e.wdata   = wd;
        e.exp_val = ev;
        e.sel     = s;
        // only a ram doubleword takes two beats
        e.beats   = (in_ram && ls == LS_D) ? 2'd2 : 2'd1;
        steps.push_back(e);
    endfunction

    function automatic void read_entry(addr_t a, ls_type_t ls, dword_t ev);
        push_entry(OP_READ, a, ls, '0, ev, SEL_M);
    endfunction

    function automatic void write_entry(addr_t a, ls_type_t ls, dword_t wd);
        push_entry(OP_WRITE, a, ls, wd, '0, SEL_M);
    endfunction

    function automatic void store_entry(addr_t a, ls_type_t ls, dword_t wd);
        model_store(a, ls, wd);
        write_entry(a, ls, wd);
    endfunction

    function automatic void load_entry(addr_t a, ls_type_t ls);
        read_entry(a, ls, model_load(a, ls));
    endfunction

    function automatic void build_steps();
        addr_t a;
        addr_t d;
        word_t lo;
        word_t hi;
        // unmapped space and reset values
        read_entry(64'h800, LS_D, '0);
        write_entry(64'h800, LS_W, 64'hdead_beef);
        read_entry(64'h800, LS_W, '0);
        read_entry(addr_t'(MTIMECMP_ADDR), LS_D, '1);
        read_entry(PRIO + 64'd24, LS_W, '0);
        // byte and halfword stores over two words
        a = addr_t'(RAM_BASE) + 64'h40;
        store_entry(a, LS_W, {32'd0, rnd()});
        store_entry(a + 1, LS_B, {32'd0, rnd() | 32'h80});
        store_entry(a + 3, LS_B, {32'd0, rnd() | 32'h80});
        store_entry(a + 4, LS_W, {32'd0, rnd() & 32'h7fff_ffff});
        store_entry(a + 4, LS_H, {32'd0, rnd() | 32'h8000});
        for (int w = 0; w < 2; w++) begin
            for (int lane = 0; lane < 4; lane++) begin
                load_entry(a + 4 * w + lane, LS_B);
                load_entry(a + 4 * w + lane, LS_BU);
                if (lane % 2 == 0) begin
                    load_entry(a + 4 * w + lane, LS_H);
                    load_entry(a + 4 * w + lane, LS_HU);
                end
                if (lane == 0) begin
                    load_entry(a + 4 * w, LS_W);
                    load_entry(a + 4 * w, LS_WU);
                end
            end
        end
        // doubleword, low word at the lower address
        d  = addr_t'(RAM_BASE) + 64'h80;
        lo = rnd();
        hi = rnd();
        store_entry(d, LS_D, {hi, lo});
        load_entry(d, LS_D);
        load_entry(d, LS_WU);
        load_entry(d + 4, LS_WU);
        // priorities, enables, thresholds
        write_entry(PRIO + 64'd4, LS_W, 64'd3);
        write_entry(PRIO + 64'd8, LS_W, 64'd5);
        write_entry(PRIO + 64'd12, LS_W, 64'd5);
        write_entry(PRIO + 64'd16, LS_W, 64'd2);
        write_entry(PRIO + 64'd20, LS_W, 64'd1);
        read_entry(PRIO + 64'd8, LS_W, 64'd5);
        write_entry(ENA0, LS_W, 64'h0e);
        write_entry(ENA1, LS_W, 64'h30);
        write_entry(THR0, LS_W, 64'd2);
        write_entry(THR1, LS_W, 64'd1);
        read_entry(ENA1, LS_WU, 64'h30);
        read_entry(THR0, LS_W, 64'd2);
        push_entry(OP_LEVEL, '0, LS_W, '0, '0, SEL_M);
        push_entry(OP_LEVEL, '0, LS_W, '0, '0, SEL_S);
        // ids 1 to 4 raised, then dropped, pending stays
        push_entry(OP_SOURCES, '0, LS_W, 64'b01111, '0, SEL_M);
        push_entry(OP_WAIT, '0, LS_W, '0, 64'd1, SEL_M);
        push_entry(OP_WAIT, '0, LS_W, '0, 64'd1, SEL_S);
        push_entry(OP_SOURCES, '0, LS_W, '0, '0, SEL_M);
        read_entry(PEND, LS_W, 64'h1e);
        // tie between 2 and 3 goes to 2, id 1 last, id 4 not enabled
        read_entry(CLM0, LS_W, 64'd2);
        read_entry(CLM0, LS_W, 64'd3);
        read_entry(CLM0, LS_W, 64'd1);
        read_entry(CLM0, LS_W, 64'd0);
        push_entry(OP_LEVEL, '0, LS_W, '0, '0, SEL_M);
        read_entry(CLM1, LS_W, 64'd4);
        read_entry(CLM1, LS_W, 64'd0);
        push_entry(OP_LEVEL, '0, LS_W, '0, '0, SEL_S);
        // id 5 sits at the context 1 threshold
        push_entry(OP_SOURCES, '0, LS_W, 64'b10000, '0, SEL_M);
        read_entry(PEND, LS_W, 64'h20);
        push_entry(OP_LEVEL, '0, LS_W, '0, '0, SEL_S);
        read_entry(CLM1, LS_W, 64'd0);
        push_entry(OP_SOURCES, '0, LS_W, '0, '0, SEL_M);
        // timer, compare set 40 ticks ahead
        push_entry(OP_TIME, addr_t'(MTIME_ADDR), LS_D, '0, '0, SEL_T);
        push_entry(OP_TIME, addr_t'(MTIME_ADDR), LS_D, '0, '0, SEL_T);
        push_entry(OP_CMP, addr_t'(MTIMECMP_ADDR), LS_D, 64'd40, '0, SEL_T);
        push_entry(OP_LEVEL, '0, LS_W, '0, '0, SEL_T);
        push_entry(OP_WAIT, '0, LS_W, '0, 64'd1, SEL_T);
    endfunction

    function automatic logic irq_level(irq_sel_t s);
        case (s)
            SEL_M:   return ext_irq_m;
            SEL_S:   return ext_irq_s;
            default: return timer_irq;
        endcase
    endfunction

    function automatic string irq_name(irq_sel_t s);
        case (s)
            SEL_M:   return "ext_irq_m";
            SEL_S:   return "ext_irq_s";
            default: return "timer_irq";
        endcase
    endfunction

    // one bus transaction, returns at the negedge where done is back high
    task automatic run_access(input entry_t e, input logic is_write, output dword_t data);
        int    edges;
        logic  done_now;
        string done_name;
        done_name = is_write ? "write_done" : "read_done";
        @(posedge CLOCK_50);
        req <= '{addr: e.addr, wdata: e.wdata, ls_type: e.ls};
        if (is_write) begin
            write_enable <= 1'b1;
        end else begin
            read_enable <= 1'b1;
        end
        // edge that samples the pulse
        @(posedge CLOCK_50);
        read_enable  <= 1'b0;
        write_enable <= 1'b0;
        @(negedge CLOCK_50);
        done_now = is_write ? write_done : read_done;
        check_level(done_name, done_now, 1'b0);
        edges = 0;
        while (!done_now) begin
            @(negedge CLOCK_50);
            edges++;
            done_now = is_write ? write_done : read_done;
            if (!done_now && edges >= 20) begin
                fail_run($sformatf("timeout: %s stayed low for 20 cycles, address %h",
                                   done_name, e.addr));
            end
        end
        check_count({done_name, " edges"}, edges, int'(e.beats));
        data = read_data;
    endtask

    task automatic wait_irq(input irq_sel_t s, input logic lvl);
        int cycles;
        cycles = 0;
        while (irq_level(s) !== lvl) begin
            @(negedge CLOCK_50);
            cycles++;
            if (irq_level(s) !== lvl && cycles >= 200) begin
                fail_run($sformatf("timeout: %s did not reach %b within 200 cycles",
                                   irq_name(s), lvl));
            end
        end
    endtask

    initial begin
        entry_t e;
        dword_t got;
        dword_t cmp;
        build_steps();
        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        @(negedge CLOCK_50);
        // idle state out of reset
        check_level("read_done", read_done, 1'b1);
        check_level("write_done", write_done, 1'b1);
        check_dword("read_data", read_data, '0);
        check_level("ext_irq_m", ext_irq_m, 1'b0);
        check_level("ext_irq_s", ext_irq_s, 1'b0);
        check_level("timer_irq", timer_irq, 1'b0);
        foreach (steps[i]) begin
            e = steps[i];
            case (e.op)
                OP_READ: begin
                    run_access(e, 1'b0, got);
                    check_dword($sformatf("read_data[%h]", e.addr), got, e.exp_val);
                end
                OP_WRITE: run_access(e, 1'b1, got);
                OP_SOURCES: begin
                    @(posedge CLOCK_50);
                    irq_sources <= e.wdata[DEFAULT_NUM_SOURCES-1:0];
                    @(negedge CLOCK_50);
                end
                OP_LEVEL: check_level(irq_name(e.sel), irq_level(e.sel), e.exp_val[0]);
                OP_WAIT: wait_irq(e.sel, e.exp_val[0]);
                OP_TIME: begin
                    run_access(e, 1'b0, got);
                    check_rising(got, last_mtime);
                    last_mtime = got;
                end
                default: begin
                    // compare value relative to the last mtime read
                    cmp     = last_mtime + e.wdata;
                    e.wdata = cmp;
                    run_access(e, 1'b1, got);
                    run_access(e, 1'b0, got);
                    check_dword("mtimecmp", got, cmp);
                end
            endcase
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- board_bus.f
src/board_bus_pkg.sv
src/addr_decoder.sv
src/bus_fsm.sv
src/word_ram.sv
src/plic.sv
src/machine_timer.sv
src/board_bus.sv
testbench/board_bus_tb.sv
